//--- sources.f
hdl/vga_pkg.sv
hdl/vga_timing.sv
hdl/vga_regs.sv
hdl/vga_palette.sv
hdl/vga_fetch.sv
hdl/vga_master.sv
verification/wb_mem_model.sv
verification/tb_vga_master.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -Wno-fatal
TOP       := tb_vga_master
FILELIST  := sources.f

SOURCES := $(shell cat $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir

//--- verification/tb_vga_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vga_master;

  localparam int H_ACTIVE = 16;
  localparam int H_FRONT  = 2;
  localparam int V_ACTIVE = 8;
  localparam int V_TOTAL  = 12;
  localparam int TIMEOUT  = 8 * 576 + 2000;
  localparam vga_pkg::addr_t FB_BASE = 32'h0000_0100;

  logic clk;
  logic rst;
  logic [1:0] default_mode;
  vga_pkg::reg_adr_t slave_adr;
  vga_pkg::data_t slave_dat;
  vga_pkg::data_t slave_dat_o;
  logic slave_we;
  vga_pkg::sel_t slave_sel;
  logic slave_cyc;
  logic slave_stb;
  logic slave_ack;
  vga_pkg::addr_t master_adr;
  vga_pkg::data_t master_dat;
  logic master_cyc;
  logic master_stb;
  logic master_we;
  vga_pkg::sel_t master_sel;
  logic master_ack;
  logic hs_o;
  logic vs_o;
  logic blank_n_o;
  logic [7:0] r_o;
  logic [7:0] g_o;
  logic [7:0] b_o;

  int seed = 32'h6196;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  vga_pkg::rgb_t pal [0:255];
  logic [7:0] fb [0:1023];
  logic check_en = 1'b0;
  logic [1:0] check_mode = vga_pkg::MODE_NORMAL;

  vga_master vga_master_i (
    .clk_i (clk), .rst_i (rst), .default_mode_i (default_mode),
    .slave_adr_i (slave_adr), .slave_dat_i (slave_dat), .slave_dat_o (slave_dat_o),
    .slave_we_i (slave_we), .slave_sel_i (slave_sel), .slave_cyc_i (slave_cyc),
    .slave_stb_i (slave_stb), .slave_ack_o (slave_ack),
    .master_adr_o (master_adr), .master_dat_i (master_dat), .master_cyc_o (master_cyc),
    .master_stb_o (master_stb), .master_we_o (master_we), .master_sel_o (master_sel),
    .master_ack_i (master_ack),
    .hs_o (hs_o), .vs_o (vs_o), .blank_n_o (blank_n_o), .r_o (r_o), .g_o (g_o), .b_o (b_o)
  );

  wb_mem_model #(.SEED (32'h6196)) mem_model_i (
    .clk_i (clk), .rst_i (rst), .adr_i (master_adr), .cyc_i (master_cyc),
    .stb_i (master_stb), .dat_o (master_dat), .ack_o (master_ack)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // Colour expected for pixel (x, y) in the given mode
  function automatic vga_pkg::rgb_t expected_rgb(input logic [1:0] mode, input int x,
                                                 input int y);
    int a;
    if (mode == vga_pkg::MODE_NORMAL) begin
      a = int'(FB_BASE) + y * H_ACTIVE + x;
    end else if (mode == vga_pkg::MODE_DOUBLE) begin
      a = int'(FB_BASE) + (y / 2) * (H_ACTIVE / 2) + x / 2;
    end else begin
      return '0;
    end
    return pal[fb[a]];
  endfunction

  task automatic bus_access(input vga_pkg::reg_adr_t adr, input logic we,
                            input vga_pkg::data_t wdat, input vga_pkg::sel_t sel,
                            input int exp_lat, output vga_pkg::data_t rdat);
    int n;
    n = 0;
    @(posedge clk);
    slave_adr <= adr;
    slave_we  <= we;
    slave_dat <= wdat;
    slave_sel <= sel;
    slave_cyc <= 1'b1;
    slave_stb <= 1'b1;
    do begin
      @(negedge clk);
      n++;
    end while (!slave_ack && n < 20);
    rdat = slave_dat_o;
    assert (slave_ack) else begin
      errors++;
      $display("no ack on slave access to address %h", adr);
    end
    assert (n - 1 == exp_lat) else begin
      errors++;
      $display("error: slave_ack_o latency at %h is %h, expected %h", adr, n - 1, exp_lat);
    end
    @(posedge clk);
    slave_cyc <= 1'b0;
    slave_stb <= 1'b0;
    slave_we  <= 1'b0;
  endtask

  task automatic write_reg(input vga_pkg::reg_adr_t adr, input vga_pkg::data_t dat,
                           input vga_pkg::sel_t sel, input int exp_lat);
    vga_pkg::data_t unused;
    bus_access(adr, 1'b1, dat, sel, exp_lat, unused);
  endtask

  task automatic read_check(input vga_pkg::reg_adr_t adr, input vga_pkg::data_t exp_val,
                            input int exp_lat);
    vga_pkg::data_t rdat;
    bus_access(adr, 1'b0, '0, 4'hf, exp_lat, rdat);
    assert (rdat == exp_val) else begin
      errors++;
      $display("error: slave_dat_o at %h is %h, expected %h", adr, rdat, exp_val);
    end
  endtask

  task automatic wait_vs_fall();
    @(negedge clk);
    while (!vs_o) @(negedge clk);
    while (vs_o) @(negedge clk);
  endtask

  // Line number from blank_n rises since vs fell and pixel from cycles since blank_n rose
  logic vs_prev = 1'b1;
  logic hs_prev = 1'b1;
  logic blank_prev = 1'b0;
  logic frame_valid = 1'b0;
  int hs_falls = 0;
  int blank_cycles = 0;
  int line = 0;
  int pix_cyc = 0;
  vga_pkg::rgb_t exp_rgb;

  always @(negedge clk) begin
    if (!rst) begin
      if (master_cyc) begin
        assert (master_stb && !master_we && master_sel == 4'hf) else begin
          errors++;
          $display("error: master_stb_o master_we_o master_sel_o are %h %h %h, expected 1 0 f",
                   master_stb, master_we, master_sel);
        end
      end
      if (vs_prev && !vs_o) begin
        if (frame_valid) begin
          assert (hs_falls == V_TOTAL) else begin
            errors++;
            $display("error: hs_o pulses per frame %h, expected %h", hs_falls, V_TOTAL);
          end
          assert (blank_cycles == 2 * H_ACTIVE * V_ACTIVE) else begin
            errors++;
            $display("error: blank_n_o cycles per frame %h, expected %h", blank_cycles,
                     2 * H_ACTIVE * V_ACTIVE);
          end
        end
        frame_valid = 1'b1;
        hs_falls = 0;
        blank_cycles = 0;
        line = -1;
      end
      if (hs_prev && !hs_o) hs_falls++;
      if (!blank_prev && blank_n_o) begin
        line++;
        pix_cyc = 0;
      end
      if (blank_n_o) begin
        blank_cycles++;
        if (check_en) begin
          exp_rgb = expected_rgb(check_mode, pix_cyc / 2, line);
          checks++;
          assert ({r_o, g_o, b_o} == exp_rgb) else begin
            errors++;
            $display("error: r_o g_o b_o at x %0d y %0d are %h, expected %h", pix_cyc / 2,
                     line, {r_o, g_o, b_o}, exp_rgb);
          end
        end
        pix_cyc++;
      end
      vs_prev = vs_o;
      hs_prev = hs_o;
      blank_prev = blank_n_o;
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    default_mode = 2'd0;
    slave_adr = '0;
    slave_dat = '0;
    slave_we = 1'b0;
    slave_sel = '0;
    slave_cyc = 1'b0;
    slave_stb = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // Reset lands in the front porch and hs stays high through it and the 3-cycle delay
    repeat (2 * H_FRONT + 3) begin
      @(negedge clk);
      assert (hs_o && vs_o && !blank_n_o) else begin
        errors++;
        $display("error: hs_o vs_o blank_n_o after reset are %h %h %h, expected 1 1 0",
                 hs_o, vs_o, blank_n_o);
      end
    end
    read_check(vga_pkg::REG_BASE_ADR, 32'hC000_0000, 1);
    read_check(vga_pkg::REG_SETUP_ADR, 32'h0, 1);

    for (int i = 0; i < 1024; i++) begin
      fb[i] = 8'($random(seed));
      mem_model_i.mem[i] = fb[i];
    end

    // Byte-selected register writes
    write_reg(vga_pkg::REG_BASE_ADR, 32'h1234_5678, 4'hf, 1);
    write_reg(vga_pkg::REG_BASE_ADR, 32'hAABB_CCDD, 4'b0101, 1);
    read_check(vga_pkg::REG_BASE_ADR, 32'h12BB_56DD, 1);
    write_reg(vga_pkg::REG_SETUP_ADR, 32'h0000_0003, 4'b0001, 1);
    write_reg(vga_pkg::REG_SETUP_ADR, 32'hFFFF_FF00, 4'b1110, 1);
    read_check(vga_pkg::REG_SETUP_ADR, 32'hFFFF_FF03, 1);
    write_reg(10'h155, 32'hDEAD_BEEF, 4'hf, 1);
    read_check(10'h155, 32'h0, 1);

    for (int i = 0; i < 256; i++) begin
      pal[i] = 24'($random(seed));
      write_reg(10'(i), {8'h00, pal[i]}, 4'hf, 2);
    end
    read_check(10'h042, 32'h0, 2);

    wait_vs_fall();
    write_reg(vga_pkg::REG_BASE_ADR, FB_BASE, 4'hf, 1);
    write_reg(vga_pkg::REG_SETUP_ADR, 32'h0, 4'hf, 1);
    wait_vs_fall();
    check_mode = vga_pkg::MODE_NORMAL;
    check_en = 1'b1;
    repeat (2) wait_vs_fall();
    check_en = 1'b0;

    write_reg(vga_pkg::REG_SETUP_ADR, 32'h1, 4'hf, 1);
    wait_vs_fall();
    check_mode = vga_pkg::MODE_DOUBLE;
    check_en = 1'b1;
    wait_vs_fall();
    check_en = 1'b0;

    write_reg(vga_pkg::REG_SETUP_ADR, 32'h2, 4'hf, 1);
    wait_vs_fall();
    check_mode = 2'd2;
    check_en = 1'b1;
    wait_vs_fall();
    check_en = 1'b0;

    assert (checks == 4 * 2 * H_ACTIVE * V_ACTIVE) else begin
      errors++;
      $display("error: checked pixel cycles %h, expected %h", checks,
               4 * 2 * H_ACTIVE * V_ACTIVE);
    end

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/wb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model #(
  parameter int SEED  = 32'h6196,
  parameter int DEPTH = 1024
) (
  input  wire logic           clk_i,
  input  wire logic           rst_i,
  input  wire vga_pkg::addr_t adr_i,
  input  wire logic           cyc_i,
  input  wire logic           stb_i,
  output vga_pkg::data_t      dat_o,
  output logic                ack_o
);

  // Frame buffer bytes that the testbench fills
  logic [7:0] mem [0:DEPTH-1];

  int         seed;
  int         delay;
  logic       busy_q;
  logic [1:0] cnt_q;

  initial begin
    seed = SEED;
  end

  function automatic vga_pkg::data_t read_word(input vga_pkg::addr_t adr);
    int a;
    a = int'(adr % DEPTH);
    a = a - (a % 4);
    return {mem[a+3], mem[a+2], mem[a+1], mem[a]};
  endfunction

  // Each request waits a random 0 to 3 cycles before its ack
  always @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ack_o  <= 1'b0;
      busy_q <= 1'b0;
      cnt_q  <= '0;
      dat_o  <= '0;
    end else begin
      ack_o <= 1'b0;
      if (cyc_i && stb_i && !ack_o) begin
        if (!busy_q) begin
          delay = $unsigned($random(seed)) % 4;
          if (delay == 0) begin
            ack_o <= 1'b1;
            dat_o <= read_word(adr_i);
          end else begin
            busy_q <= 1'b1;
            cnt_q  <= 2'(delay);
          end
        end else if (cnt_q == 2'd1) begin
          ack_o  <= 1'b1;
          dat_o  <= read_word(adr_i);
          busy_q <= 1'b0;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/vga_master.sv
`timescale 1ns/1ps
`default_nettype none

module vga_master #(
  parameter int             H_ACTIVE   = 16,
  parameter int             H_FRONT    = 2,
  parameter int             H_SYNC     = 4,
  parameter int             H_BACK     = 2,
  parameter int             V_ACTIVE   = 8,
  parameter int             V_FRONT    = 1,
  parameter int             V_SYNC     = 2,
  parameter int             V_BACK     = 1,
  parameter vga_pkg::addr_t BASE_RESET = 32'hC000_0000
) (
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  input  wire logic [1:0]        default_mode_i,
  input  wire vga_pkg::reg_adr_t slave_adr_i,
  input  wire vga_pkg::data_t    slave_dat_i,
  output vga_pkg::data_t         slave_dat_o,
  input  wire logic              slave_we_i,
  input  wire vga_pkg::sel_t     slave_sel_i,
  input  wire logic              slave_cyc_i,
  input  wire logic              slave_stb_i,
  output logic                   slave_ack_o,
  output vga_pkg::addr_t         master_adr_o,
  input  wire vga_pkg::data_t    master_dat_i,
  output logic                   master_cyc_o,
  output logic                   master_stb_o,
  output logic                   master_we_o,
  output vga_pkg::sel_t          master_sel_o,
  input  wire logic              master_ack_i,
  output logic                   hs_o,
  output logic                   vs_o,
  output logic                   blank_n_o,
  output logic [7:0]             r_o,
  output logic [7:0]             g_o,
  output logic [7:0]             b_o
);

  vga_pkg::addr_t    base;
  logic              pixel_double;
  logic              display_en;
  logic              pal_we;
  vga_pkg::pal_idx_t pal_adr;
  vga_pkg::rgb_t     pal_dat;
  vga_pkg::rgb_t     pal_rdat;
  logic              pix_en;
  logic              active;
  logic              hs;
  logic              vs;
  logic              line_start;
  logic              frame_start;
  vga_pkg::coord_t   y;
  vga_pkg::pal_idx_t pix_idx;
  logic              pix_black;
  logic              black_q;
  logic [2:0]        hs_d;
  logic [2:0]        vs_d;
  logic [2:0]        act_d;
  vga_pkg::rgb_t     rgb_q;

  // Read-only master
  assign master_we_o  = 1'b0;
  assign master_sel_o = '1;
  assign master_stb_o = master_cyc_o;

  vga_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) vga_timing_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .pix_en_o      (pix_en),
    .x_o           (),
    .y_o           (y),
    .active_o      (active),
    .hs_o          (hs),
    .vs_o          (vs),
    .line_start_o  (line_start),
    .frame_start_o (frame_start)
  );

  vga_regs #(
    .BASE_RESET (BASE_RESET)
  ) vga_regs_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .slave_adr_i    (slave_adr_i),
    .slave_dat_i    (slave_dat_i),
    .slave_we_i     (slave_we_i),
    .slave_cyc_i    (slave_cyc_i),
    .slave_stb_i    (slave_stb_i),
    .slave_sel_i    (slave_sel_i),
    .default_mode_i (default_mode_i),
    .slave_dat_o    (slave_dat_o),
    .slave_ack_o    (slave_ack_o),
    .base_o         (base),
    .pixel_double_o (pixel_double),
    .display_en_o   (display_en),
    .pal_we_o       (pal_we),
    .pal_adr_o      (pal_adr),
    .pal_dat_o      (pal_dat)
  );

  vga_fetch #(
    .H_ACTIVE (H_ACTIVE)
  ) vga_fetch_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .base_i         (base),
    .pixel_double_i (pixel_double),
    .pix_en_i       (pix_en),
    .active_i       (active),
    .line_start_i   (line_start),
    .frame_start_i  (frame_start),
    .y_lsb_i        (y[0]),
    .master_dat_i   (master_dat_i),
    .master_ack_i   (master_ack_i),
    .master_adr_o   (master_adr_o),
    .master_cyc_o   (master_cyc_o),
    .pix_idx_o      (pix_idx),
    .pix_black_o    (pix_black)
  );

  vga_palette vga_palette_i (
    .clk_i  (clk_i),
    .we_i   (pal_we),
    .wadr_i (pal_adr),
    .wdat_i (pal_dat),
    .radr_i (pix_idx),
    .rdat_o (pal_rdat)
  );

  // Stage 1 fetch index, stage 2 palette, stage 3 colour register
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      hs_d    <= '1;
      vs_d    <= '1;
      act_d   <= '0;
      black_q <= 1'b1;
      rgb_q   <= '0;
    end else begin
      hs_d    <= {hs_d[1:0], hs};
      vs_d    <= {vs_d[1:0], vs};
      act_d   <= {act_d[1:0], active};
      black_q <= pix_black;
      if (act_d[1] && display_en && !black_q) begin
        rgb_q <= pal_rdat;
      end else begin
        rgb_q <= '0;
      end
    end
  end

  assign hs_o      = hs_d[2];
  assign vs_o      = vs_d[2];
  assign blank_n_o = act_d[2];
  assign r_o       = rgb_q[23:16];
  assign g_o       = rgb_q[15:8];
  assign b_o       = rgb_q[7:0];

endmodule

`default_nettype wire

//--- hdl/vga_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module vga_fetch #(
  parameter int H_ACTIVE = 16
) (
  input  wire logic            clk_i,
  input  wire logic            rst_i,
  input  wire vga_pkg::addr_t  base_i,
  input  wire logic            pixel_double_i,
  input  wire logic            pix_en_i,
  input  wire logic            active_i,
  input  wire logic            line_start_i,
  input  wire logic            frame_start_i,
  input  wire logic            y_lsb_i,
  input  wire vga_pkg::data_t  master_dat_i,
  input  wire logic            master_ack_i,
  output vga_pkg::addr_t       master_adr_o,
  output logic                 master_cyc_o,
  output vga_pkg::pal_idx_t    pix_idx_o,
  output logic                 pix_black_o
);

  typedef enum logic {
    FS_IDLE,
    FS_BUSY
  } fstate_e;

  fstate_e         fstate_q;
  vga_pkg::addr_t  fetch_adr_q;
  vga_pkg::addr_t  line_adr_q;
  vga_pkg::coord_t words_left_q;
  vga_pkg::data_t  cur_q;
  vga_pkg::data_t  pre_q;
  logic            cur_vld_q;
  logic            pre_vld_q;
  logic            stale_q;
  logic [1:0]      byte_q;
  logic            half_q;
  logic            active_q;

  logic            adv;
  logic            word_end;
  logic            flush;
  logic            ack;
  logic            load_cur;
  logic            load_pre;
  vga_pkg::addr_t  stride;
  vga_pkg::addr_t  load_adr;
  vga_pkg::coord_t line_words;

  assign adv      = pix_en_i && active_i;
  assign word_end = adv && (byte_q == 2'd3) && (!pixel_double_i || half_q);
  // End of an active line or a new frame both restart the line fetch
  assign flush    = frame_start_i || (active_q && !active_i);
  assign ack      = (fstate_q == FS_BUSY) && master_ack_i;

  // Only one read is outstanding and it is issued with pre empty
  assign load_cur = ack && !stale_q && (!cur_vld_q || word_end);
  assign load_pre = ack && !stale_q && cur_vld_q && !word_end;

  assign stride     = pixel_double_i ? vga_pkg::addr_t'(H_ACTIVE / 2) :
                                       vga_pkg::addr_t'(H_ACTIVE);
  assign line_words = pixel_double_i ? vga_pkg::coord_t'(H_ACTIVE / 8) :
                                       vga_pkg::coord_t'(H_ACTIVE / 4);

  // Odd lines in double mode show the line before them again
  always_comb begin
    if (frame_start_i) begin
      load_adr = base_i;
    end else if (pixel_double_i && y_lsb_i) begin
      load_adr = line_adr_q;
    end else begin
      load_adr = line_adr_q + stride;
    end
  end

  assign master_cyc_o = (fstate_q == FS_BUSY);

  always_ff @(posedge clk_i) begin
    if (load_cur) begin
      cur_q <= master_dat_i;
    end else if (word_end) begin
      cur_q <= pre_q;
    end
    if (load_pre) begin
      pre_q <= master_dat_i;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      fstate_q     <= FS_IDLE;
      master_adr_o <= '0;
      fetch_adr_q  <= '0;
      line_adr_q   <= '0;
      words_left_q <= '0;
      cur_vld_q    <= 1'b0;
      pre_vld_q    <= 1'b0;
      stale_q      <= 1'b0;
      byte_q       <= '0;
      half_q       <= 1'b0;
      active_q     <= 1'b0;
      pix_idx_o    <= '0;
      pix_black_o  <= 1'b1;
    end else begin
      active_q <= active_i;

      case (fstate_q)
        FS_IDLE: begin
          if ((words_left_q != '0) && !pre_vld_q && !flush) begin
            fstate_q     <= FS_BUSY;
            master_adr_o <= fetch_adr_q;
            fetch_adr_q  <= fetch_adr_q + 32'd4;
            words_left_q <= words_left_q - 1'b1;
          end
        end
        default: begin
          if (master_ack_i) begin
            fstate_q <= FS_IDLE;
            stale_q  <= 1'b0;
          end
        end
      endcase

      if (word_end) begin
        cur_vld_q <= pre_vld_q;
        pre_vld_q <= 1'b0;
      end
      if (load_cur) begin
        cur_vld_q <= 1'b1;
      end
      if (load_pre) begin
        pre_vld_q <= 1'b1;
      end

      if (adv) begin
        if (pixel_double_i) begin
          half_q <= ~half_q;
        end
        if (!pixel_double_i || half_q) begin
          byte_q <= byte_q + 1'b1;
        end
      end

      // Index changes once per pixel, on its first clock
      if (!pix_en_i) begin
        pix_idx_o   <= cur_vld_q ? cur_q[8*byte_q +: 8] : '0;
        pix_black_o <= !cur_vld_q;
      end

      if (flush) begin
        line_adr_q   <= load_adr;
        fetch_adr_q  <= load_adr;
        words_left_q <= line_words;
        cur_vld_q    <= 1'b0;
        pre_vld_q    <= 1'b0;
        // A read still in flight belongs to the old line
        if ((fstate_q == FS_BUSY) && !master_ack_i) begin
          stale_q <= 1'b1;
        end
      end

      if (line_start_i) begin
        byte_q <= '0;
        half_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/vga_palette.sv
`timescale 1ns/1ps
`default_nettype none

module vga_palette (
  input  wire logic              clk_i,
  input  wire logic              we_i,
  input  wire vga_pkg::pal_idx_t wadr_i,
  input  wire vga_pkg::rgb_t     wdat_i,
  input  wire vga_pkg::pal_idx_t radr_i,
  output vga_pkg::rgb_t          rdat_o
);

  vga_pkg::rgb_t mem_q [0:255];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[wadr_i] <= wdat_i;
    end
  end

  // Registered read, data one cycle after the index
  always_ff @(posedge clk_i) begin
    rdat_o <= mem_q[radr_i];
  end

endmodule

`default_nettype wire

//--- hdl/vga_regs.sv
`timescale 1ns/1ps
`default_nettype none

module vga_regs #(
  parameter vga_pkg::addr_t BASE_RESET = 32'hC000_0000
) (
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  input  wire vga_pkg::reg_adr_t slave_adr_i,
  input  wire vga_pkg::data_t    slave_dat_i,
  input  wire logic              slave_we_i,
  input  wire logic              slave_cyc_i,
  input  wire logic              slave_stb_i,
  input  wire vga_pkg::sel_t     slave_sel_i,
  input  wire logic [1:0]        default_mode_i,
  output vga_pkg::data_t         slave_dat_o,
  output logic                   slave_ack_o,
  output vga_pkg::addr_t         base_o,
  output logic                   pixel_double_o,
  output logic                   display_en_o,
  output logic                   pal_we_o,
  output vga_pkg::pal_idx_t      pal_adr_o,
  output vga_pkg::rgb_t          pal_dat_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PALETTE,
    ST_DONE
  } state_e;

  state_e         state_q;
  vga_pkg::data_t setup_q;
  logic           req;
  logic           pal_hit;
  logic [1:0]     mode;

  function automatic vga_pkg::data_t merge_bytes(input vga_pkg::data_t old_val,
                                                 input vga_pkg::data_t new_val,
                                                 input vga_pkg::sel_t  sel);
    vga_pkg::data_t res;
    res = old_val;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign req     = slave_cyc_i && slave_stb_i;
  assign pal_hit = (slave_adr_i[9:8] == 2'b00);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q     <= ST_IDLE;
      base_o      <= BASE_RESET;
      setup_q     <= {30'b0, default_mode_i};
      slave_dat_o <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req) begin
            // Palette and unmapped reads return 0
            slave_dat_o <= '0;
            if (pal_hit) begin
              state_q <= ST_PALETTE;
            end else begin
              state_q <= ST_DONE;
              if (slave_adr_i == vga_pkg::REG_BASE_ADR) begin
                if (slave_we_i) begin
                  base_o <= merge_bytes(base_o, slave_dat_i, slave_sel_i);
                end else begin
                  slave_dat_o <= base_o;
                end
              end else if (slave_adr_i == vga_pkg::REG_SETUP_ADR) begin
                if (slave_we_i) begin
                  setup_q <= merge_bytes(setup_q, slave_dat_i, slave_sel_i);
                end else begin
                  slave_dat_o <= setup_q;
                end
              end
            end
          end
        end
        ST_PALETTE: begin
          state_q <= ST_DONE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  assign slave_ack_o = (state_q == ST_DONE);

  // Request is held until ack, so the bus fields are still valid here
  assign pal_we_o  = (state_q == ST_PALETTE) && slave_we_i;
  assign pal_adr_o = slave_adr_i[7:0];
  assign pal_dat_o = slave_dat_i[23:0];

  assign mode           = setup_q[1:0];
  assign pixel_double_o = (mode == vga_pkg::MODE_DOUBLE);
  assign display_en_o   = (mode == vga_pkg::MODE_NORMAL) || (mode == vga_pkg::MODE_DOUBLE);

endmodule

`default_nettype wire

//--- hdl/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
  parameter int H_ACTIVE = 16,
  parameter int H_FRONT  = 2,
  parameter int H_SYNC   = 4,
  parameter int H_BACK   = 2,
  parameter int V_ACTIVE = 8,
  parameter int V_FRONT  = 1,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 1
) (
  input  wire logic       clk_i,
  input  wire logic       rst_i,
  output logic            pix_en_o,
  output vga_pkg::coord_t x_o,
  output vga_pkg::coord_t y_o,
  output logic            active_o,
  output logic            hs_o,
  output logic            vs_o,
  output logic            line_start_o,
  output logic            frame_start_o
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  localparam vga_pkg::coord_t H_ACT   = vga_pkg::coord_t'(H_ACTIVE);
  localparam vga_pkg::coord_t H_LAST  = vga_pkg::coord_t'(H_TOTAL - 1);
  localparam vga_pkg::coord_t H_SS    = vga_pkg::coord_t'(H_ACTIVE + H_FRONT);
  localparam vga_pkg::coord_t H_SE    = vga_pkg::coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
  localparam vga_pkg::coord_t V_ACT   = vga_pkg::coord_t'(V_ACTIVE);
  localparam vga_pkg::coord_t V_LAST  = vga_pkg::coord_t'(V_TOTAL - 1);
  localparam vga_pkg::coord_t V_SS    = vga_pkg::coord_t'(V_ACTIVE + V_FRONT);
  localparam vga_pkg::coord_t V_SE    = vga_pkg::coord_t'(V_ACTIVE + V_FRONT + V_SYNC);

  vga_pkg::coord_t h_nxt;
  vga_pkg::coord_t v_nxt;

  // Counters move on the pix_en clock; the line count steps at the end of
  // the active part, so y_o already names the coming line during blanking
  always_comb begin
    h_nxt = x_o;
    v_nxt = y_o;
    if (pix_en_o) begin
      if (x_o == H_LAST) begin
        h_nxt = '0;
      end else begin
        h_nxt = x_o + 1'b1;
      end
      if (x_o == H_ACT - 1'b1) begin
        if (y_o == V_LAST) begin
          v_nxt = '0;
        end else begin
          v_nxt = y_o + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      pix_en_o      <= 1'b0;
      x_o           <= H_ACT;
      y_o           <= V_ACT;
      active_o      <= 1'b0;
      hs_o          <= 1'b1;
      vs_o          <= 1'b1;
      line_start_o  <= 1'b0;
      // Start in vertical blanking so fetch picks up the base at once
      frame_start_o <= 1'b1;
    end else begin
      pix_en_o      <= ~pix_en_o;
      x_o           <= h_nxt;
      y_o           <= v_nxt;
      active_o      <= (h_nxt < H_ACT) && (v_nxt < V_ACT);
      hs_o          <= !((h_nxt >= H_SS) && (h_nxt < H_SE));
      vs_o          <= !((v_nxt >= V_SS) && (v_nxt < V_SE));
      line_start_o  <= pix_en_o && (h_nxt == H_LAST) && (v_nxt < V_ACT);
      frame_start_o <= pix_en_o && (h_nxt == H_ACT) && (v_nxt == V_ACT);
    end
  end

endmodule

`default_nettype wire

//--- hdl/vga_pkg.sv
`default_nettype none

package vga_pkg;

  // Bus side
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  sel_t;

  // Red in [23:16], green in [15:8], blue in [7:0]
  typedef logic [23:0] rgb_t;
  typedef logic [7:0]  pal_idx_t;

  // Pixel and line counters
  typedef logic [9:0]  coord_t;

  // Slave word address
  typedef logic [9:0]  reg_adr_t;

  // Register map, palette lives at 0x000 to 0x0ff
  localparam reg_adr_t REG_BASE_ADR  = 10'h300;
  localparam reg_adr_t REG_SETUP_ADR = 10'h301;

  // Setup register mode field, bits [1:0]
  localparam logic [1:0] MODE_NORMAL = 2'd0;
  localparam logic [1:0] MODE_DOUBLE = 2'd1;

endpackage

`default_nettype wire
